// ==== hw/soc_pkg.sv ====
// System fabric package with the memory map, bus widths and bus structs
package soc_pkg;

    localparam int unsigned AddrWidth = 32;
    localparam int unsigned DataWidth = 32;
    localparam int unsigned StrbWidth = DataWidth / 8;

    // Memory map
    localparam logic [AddrWidth-1:0] RomBase     = 32'h0000_1000;
    localparam logic [AddrWidth-1:0] RomLength   = 32'h0000_0040;
    localparam logic [AddrWidth-1:0] ClintBase   = 32'h0200_0000;
    localparam logic [AddrWidth-1:0] ClintLength = 32'h0000_0010;
    localparam logic [AddrWidth-1:0] DramBase    = 32'h8000_0000;

    // CLINT register offsets
    localparam logic [3:0] ClintMsipOff     = 4'h0;
    localparam logic [3:0] ClintMtimecmpOff = 4'h4;
    localparam logic [3:0] ClintMtimeOff    = 4'h8;

    typedef struct packed {
        logic                 we;
        logic [AddrWidth-1:0] addr;
        logic [StrbWidth-1:0] be;
        logic [DataWidth-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [DataWidth-1:0] rdata;
        logic                 err;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        RegionNone,
        RegionRom,
        RegionClint,
        RegionDram
    } region_e;

    // Merge the enabled bytes of wdata into old
    function automatic logic [DataWidth-1:0] apply_be(
        input logic [DataWidth-1:0] old,
        input logic [DataWidth-1:0] wdata,
        input logic [StrbWidth-1:0] be
    );
        logic [DataWidth-1:0] res;
        res = old;
        for (int i = 0; i < StrbWidth; i++) begin
            if (be[i]) res[8*i +: 8] = wdata[8*i +: 8];
        end
        return res;
    endfunction

endpackage

// ==== hw/soc_rstgen.sv ====
// System reset generator combining power-on reset and debug ndmreset
`timescale 1ns/100ps

module soc_rstgen (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic ndmreset_i,
    output logic sys_rst_n_o
);

    logic rst_req;
    logic sync_q1;
    logic sync_q2;

    assign rst_req = !rst_n_i || ndmreset_i;

    // Two clean cycles before release
    always_ff @(posedge clk_i) begin
        if (rst_req) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
        end else begin
            sync_q1 <= 1'b1;
            sync_q2 <= sync_q1;
        end
    end

    // Assertion is immediate, release goes through the synchronizer
    assign sys_rst_n_o = sync_q2 && !rst_req;

endmodule

// ==== hw/soc_arbiter.sv ====
// Fixed-priority bus arbiter for the debug and core masters with response return
`timescale 1ns/100ps

module soc_arbiter (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              core_req_valid_i,
    input  soc_pkg::bus_req_t core_req_i,
    input  logic              dbg_req_valid_i,
    input  soc_pkg::bus_req_t dbg_req_i,
    input  soc_pkg::bus_rsp_t rsp_i,
    output logic              core_gnt_o,
    output logic              dbg_gnt_o,
    output logic              core_rsp_valid_o,
    output soc_pkg::bus_rsp_t core_rsp_o,
    output logic              dbg_rsp_valid_o,
    output soc_pkg::bus_rsp_t dbg_rsp_o,
    output logic              bus_valid_o,
    output soc_pkg::bus_req_t bus_req_o
);

    logic pending_q;
    logic owner_dbg_q;

    // --------------------------------------------------
    // Grant, debug wins
    // --------------------------------------------------
    assign dbg_gnt_o   = dbg_req_valid_i;
    assign core_gnt_o  = core_req_valid_i && !dbg_req_valid_i;
    assign bus_valid_o = dbg_req_valid_i || core_req_valid_i;
    assign bus_req_o   = dbg_req_valid_i ? dbg_req_i : core_req_i;

    // --------------------------------------------------
    // Owner of the response in flight
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q   <= 1'b0;
            owner_dbg_q <= 1'b0;
        end else begin
            pending_q   <= bus_valid_o;
            owner_dbg_q <= dbg_req_valid_i;
        end
    end

    assign dbg_rsp_valid_o  = pending_q && owner_dbg_q;
    assign core_rsp_valid_o = pending_q && !owner_dbg_q;

    // Data is shared, the valid strobes tell the owner
    assign dbg_rsp_o  = rsp_i;
    assign core_rsp_o = rsp_i;

endmodule

// ==== hw/soc_decoder.sv ====
// Address decoder with target selects, error response and read-data mux
`timescale 1ns/100ps

module soc_decoder #(
    parameter int unsigned SramWords = 1024
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                bus_valid_i,
    input  soc_pkg::bus_req_t                   bus_req_i,
    input  logic [soc_pkg::DataWidth-1:0]       rom_rdata_i,
    input  logic [soc_pkg::DataWidth-1:0]       clint_rdata_i,
    input  logic [soc_pkg::DataWidth-1:0]       dram_rdata_i,
    output logic                                rom_sel_o,
    output logic                                clint_sel_o,
    output logic                                dram_sel_o,
    output soc_pkg::bus_req_t                   tgt_req_o,
    output soc_pkg::bus_rsp_t                   rsp_o
);

    localparam logic [soc_pkg::AddrWidth-1:0] DramLength = SramWords * 4;

    soc_pkg::region_e region;
    soc_pkg::region_e region_q;
    logic             err;
    logic             err_q;

    always_comb begin
        region = soc_pkg::RegionNone;
        if (bus_req_i.addr >= soc_pkg::RomBase &&
            bus_req_i.addr < soc_pkg::RomBase + soc_pkg::RomLength) begin
            region = soc_pkg::RegionRom;
        end else if (bus_req_i.addr >= soc_pkg::ClintBase &&
                     bus_req_i.addr < soc_pkg::ClintBase + soc_pkg::ClintLength) begin
            region = soc_pkg::RegionClint;
        end else if (bus_req_i.addr >= soc_pkg::DramBase &&
                     bus_req_i.addr < soc_pkg::DramBase + DramLength) begin
            region = soc_pkg::RegionDram;
        end
    end

    // ROM is read only
    assign err = (region == soc_pkg::RegionNone) ||
                 (region == soc_pkg::RegionRom && bus_req_i.we);

    assign rom_sel_o   = bus_valid_i && !err && region == soc_pkg::RegionRom;
    assign clint_sel_o = bus_valid_i && region == soc_pkg::RegionClint;
    assign dram_sel_o  = bus_valid_i && region == soc_pkg::RegionDram;
    assign tgt_req_o   = bus_req_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            region_q <= soc_pkg::RegionNone;
            err_q    <= 1'b0;
        end else begin
            region_q <= (bus_valid_i && !err) ? region : soc_pkg::RegionNone;
            err_q    <= bus_valid_i && err;
        end
    end

    always_comb begin
        rsp_o.err = err_q;
        unique case (region_q)
            soc_pkg::RegionRom:   rsp_o.rdata = rom_rdata_i;
            soc_pkg::RegionClint: rsp_o.rdata = clint_rdata_i;
            soc_pkg::RegionDram:  rsp_o.rdata = dram_rdata_i;
            default:              rsp_o.rdata = '0;
        endcase
    end

endmodule

// ==== hw/soc_bootrom.sv ====
// Boot ROM, a read-only word table loaded from a hex image
`timescale 1ns/100ps

module soc_bootrom (
    input  logic                          clk_i,
    input  logic                          sel_i,
    input  logic [soc_pkg::AddrWidth-1:0] addr_i,
    output logic [soc_pkg::DataWidth-1:0] rdata_o
);

    localparam int unsigned RomWords = soc_pkg::RomLength / 4;
    localparam int unsigned IdxWidth = $clog2(RomWords);

    logic [soc_pkg::DataWidth-1:0] mem [RomWords];
    logic [IdxWidth-1:0]           idx;
    logic [soc_pkg::DataWidth-1:0] rdata_q;

    initial begin
        $readmemh("hw/bootrom.hex", mem);
    end

    // Word index, byte offset dropped
    assign idx = addr_i[IdxWidth+1:2];

    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            rdata_q <= mem[idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== hw/soc_sram.sv ====
// Data SRAM with byte-enabled writes and a registered read
`timescale 1ns/100ps

module soc_sram #(
    parameter int unsigned SramWords = 1024
) (
    input  logic                          clk_i,
    input  logic                          sel_i,
    input  soc_pkg::bus_req_t             req_i,
    output logic [soc_pkg::DataWidth-1:0] rdata_o
);

    localparam int unsigned IdxWidth = $clog2(SramWords);

    logic [soc_pkg::DataWidth-1:0] mem [SramWords];
    logic [IdxWidth-1:0]           idx;
    logic [soc_pkg::DataWidth-1:0] rdata_q;

    assign idx = req_i.addr[IdxWidth+1:2];

    // Byte-enabled write or registered read
    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            if (req_i.we) begin
                mem[idx] <= soc_pkg::apply_be(mem[idx], req_i.wdata, req_i.be);
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== hw/soc_clint.sv ====
// Core-local interruptor with timer, timer compare and software interrupt
`timescale 1ns/100ps

module soc_clint (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          sel_i,
    input  soc_pkg::bus_req_t             req_i,
    input  logic                          rtc_i,
    output logic [soc_pkg::DataWidth-1:0] rdata_o,
    output logic                          timer_irq_o,
    output logic                          ipi_o
);

    logic [3:0]                    off;
    logic                          wr_en;
    logic                          rd_en;
    logic [soc_pkg::DataWidth-1:0] cur_word;
    logic [soc_pkg::DataWidth-1:0] new_word;

    logic                          msip_q;
    logic [soc_pkg::DataWidth-1:0] mtime_q;
    logic [soc_pkg::DataWidth-1:0] mtimecmp_q;
    logic                          timer_irq_q;
    logic [2:0]                    rtc_sync_q;
    logic                          rtc_tick;
    logic [soc_pkg::DataWidth-1:0] rdata_q;

    assign off   = {req_i.addr[3:2], 2'b00};
    assign wr_en = sel_i && req_i.we;
    assign rd_en = sel_i && !req_i.we;

    // --------------------------------------------------
    // Register file access
    // --------------------------------------------------
    always_comb begin
        case (off)
            soc_pkg::ClintMsipOff:     cur_word = {{(soc_pkg::DataWidth-1){1'b0}}, msip_q};
            soc_pkg::ClintMtimecmpOff: cur_word = mtimecmp_q;
            soc_pkg::ClintMtimeOff:    cur_word = mtime_q;
            default:                   cur_word = '0;
        endcase
    end

    assign new_word = soc_pkg::apply_be(cur_word, req_i.wdata, req_i.be);

    // Two-stage sync, third flop for the edge
    assign rtc_tick = rtc_sync_q[1] && !rtc_sync_q[2];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            msip_q      <= 1'b0;
            mtime_q     <= '0;
            mtimecmp_q  <= '1;
            timer_irq_q <= 1'b0;
            rtc_sync_q  <= '0;
        end else begin
            rtc_sync_q  <= {rtc_sync_q[1:0], rtc_i};
            timer_irq_q <= (mtime_q >= mtimecmp_q);
            if (wr_en && off == soc_pkg::ClintMsipOff) begin
                msip_q <= new_word[0];
            end
            if (wr_en && off == soc_pkg::ClintMtimecmpOff) begin
                mtimecmp_q <= new_word;
            end
            // Bus write wins over the tick
            if (wr_en && off == soc_pkg::ClintMtimeOff) begin
                mtime_q <= new_word;
            end else if (rtc_tick) begin
                mtime_q <= mtime_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= cur_word;
        end
    end

    assign rdata_o     = rdata_q;
    assign timer_irq_o = timer_irq_q;
    assign ipi_o       = msip_q;

endmodule

// ==== hw/mini_soc.sv ====
// Mini SoC top level with reset, arbitration, decode and three targets
`timescale 1ns/100ps

module mini_soc #(
    parameter int unsigned SramWords = 1024
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              rtc_i,
    input  logic              ndmreset_i,
    input  logic              core_req_valid_i,
    input  soc_pkg::bus_req_t core_req_i,
    output logic              core_gnt_o,
    output logic              core_rsp_valid_o,
    output soc_pkg::bus_rsp_t core_rsp_o,
    input  logic              debug_req_valid_i,
    input  soc_pkg::bus_req_t debug_req_i,
    output logic              debug_gnt_o,
    output logic              debug_rsp_valid_o,
    output soc_pkg::bus_rsp_t debug_rsp_o,
    output logic              timer_irq_o,
    output logic              ipi_o
);

    logic                          sys_rst_n;
    logic                          bus_valid;
    soc_pkg::bus_req_t             bus_req;
    soc_pkg::bus_req_t             tgt_req;
    soc_pkg::bus_rsp_t             rsp;
    logic                          rom_sel;
    logic                          clint_sel;
    logic                          dram_sel;
    logic [soc_pkg::DataWidth-1:0] rom_rdata;
    logic [soc_pkg::DataWidth-1:0] clint_rdata;
    logic [soc_pkg::DataWidth-1:0] dram_rdata;

    soc_rstgen i_soc_rstgen (
        .clk_i       ( clk_i      ),
        .rst_n_i     ( rst_n_i    ),
        .ndmreset_i  ( ndmreset_i ),
        .sys_rst_n_o ( sys_rst_n  )
    );

    // --------------------------------------------------
    // Fabric
    // --------------------------------------------------
    soc_arbiter i_soc_arbiter (
        .clk_i            ( clk_i             ),
        .rst_n_i          ( sys_rst_n         ),
        .core_req_valid_i ( core_req_valid_i  ),
        .core_req_i       ( core_req_i        ),
        .dbg_req_valid_i  ( debug_req_valid_i ),
        .dbg_req_i        ( debug_req_i       ),
        .rsp_i            ( rsp               ),
        .core_gnt_o       ( core_gnt_o        ),
        .dbg_gnt_o        ( debug_gnt_o       ),
        .core_rsp_valid_o ( core_rsp_valid_o  ),
        .core_rsp_o       ( core_rsp_o        ),
        .dbg_rsp_valid_o  ( debug_rsp_valid_o ),
        .dbg_rsp_o        ( debug_rsp_o       ),
        .bus_valid_o      ( bus_valid         ),
        .bus_req_o        ( bus_req           )
    );

    soc_decoder #(
        .SramWords ( SramWords )
    ) i_soc_decoder (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( sys_rst_n   ),
        .bus_valid_i   ( bus_valid   ),
        .bus_req_i     ( bus_req     ),
        .rom_rdata_i   ( rom_rdata   ),
        .clint_rdata_i ( clint_rdata ),
        .dram_rdata_i  ( dram_rdata  ),
        .rom_sel_o     ( rom_sel     ),
        .clint_sel_o   ( clint_sel   ),
        .dram_sel_o    ( dram_sel    ),
        .tgt_req_o     ( tgt_req     ),
        .rsp_o         ( rsp         )
    );

    // --------------------------------------------------
    // Targets
    // --------------------------------------------------
    soc_bootrom i_soc_bootrom (
        .clk_i   ( clk_i        ),
        .sel_i   ( rom_sel      ),
        .addr_i  ( tgt_req.addr ),
        .rdata_o ( rom_rdata    )
    );

    soc_sram #(
        .SramWords ( SramWords )
    ) i_soc_sram (
        .clk_i   ( clk_i      ),
        .sel_i   ( dram_sel   ),
        .req_i   ( tgt_req    ),
        .rdata_o ( dram_rdata )
    );

    soc_clint i_soc_clint (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( sys_rst_n   ),
        .sel_i       ( clint_sel   ),
        .req_i       ( tgt_req     ),
        .rtc_i       ( rtc_i       ),
        .rdata_o     ( clint_rdata ),
        .timer_irq_o ( timer_irq_o ),
        .ipi_o       ( ipi_o       )
    );

endmodule

// ==== bench/mini_soc_assert.sv ====
// Bus protocol and interrupt assertions bound into the mini SoC top level
`timescale 1ns/100ps

module mini_soc_assert (
    input  logic              clk_i,
    input  logic              sys_rst_n_i,
    input  logic              core_gnt_i,
    input  logic              debug_gnt_i,
    input  logic              core_rsp_valid_i,
    input  logic              debug_rsp_valid_i,
    input  logic              clint_sel_i,
    input  soc_pkg::bus_req_t tgt_req_i,
    input  logic              ipi_i
);

    int unsigned fail_cnt = 0;
    logic        msip_wr;

    assign msip_wr = clint_sel_i && tgt_req_i.we && tgt_req_i.be[0] &&
                     tgt_req_i.addr[3:2] == 2'b00;

    grant_onehot: assert property (@(posedge clk_i) !(core_gnt_i && debug_gnt_i))
        else begin
            fail_cnt++;
            $error("Core and debug granted in the same cycle");
        end

    // --------------------------------------------------
    // Response goes to the granted master only
    // --------------------------------------------------
    debug_rsp: assert property (@(posedge clk_i) disable iff (!sys_rst_n_i)
        debug_gnt_i |=> debug_rsp_valid_i && !core_rsp_valid_i)
        else begin
            fail_cnt++;
            $error("Debug grant not followed by a debug response");
        end

    core_rsp: assert property (@(posedge clk_i) disable iff (!sys_rst_n_i)
        core_gnt_i |=> core_rsp_valid_i && !debug_rsp_valid_i)
        else begin
            fail_cnt++;
            $error("Core grant not followed by a core response");
        end

    rsp_in_reset: assert property (@(posedge clk_i)
        !sys_rst_n_i ##1 !sys_rst_n_i |-> !core_rsp_valid_i && !debug_rsp_valid_i)
        else begin
            fail_cnt++;
            $error("Response valid during system reset");
        end

    // msip clears in reset, so ipi may only rise after a write
    ipi_rise: assert property (@(posedge clk_i) disable iff (!sys_rst_n_i)
        $rose(ipi_i) |-> $past(msip_wr))
        else begin
            fail_cnt++;
            $error("Software interrupt raised without an msip write");
        end

endmodule

bind mini_soc mini_soc_assert i_mini_soc_assert (
    .clk_i             ( clk_i             ),
    .sys_rst_n_i       ( sys_rst_n         ),
    .core_gnt_i        ( core_gnt_o        ),
    .debug_gnt_i       ( debug_gnt_o       ),
    .core_rsp_valid_i  ( core_rsp_valid_o  ),
    .debug_rsp_valid_i ( debug_rsp_valid_o ),
    .clint_sel_i       ( clint_sel         ),
    .tgt_req_i         ( tgt_req           ),
    .ipi_i             ( ipi_o             )
);

// ==== bench/tb_mini_soc.sv ====
// Testbench for the mini SoC with random bus traffic against a reference model
`timescale 1ns/100ps

module tb_mini_soc;

    localparam int unsigned SramWords   = 64;
    localparam int unsigned ResetCycles = 10;
    localparam int unsigned NumRomRd    = 16;
    localparam int unsigned NumRomWr    = 4;
    localparam int unsigned NumSramRnd  = 60;
    localparam int unsigned NumArb      = 8;
    localparam int unsigned NumUnmapped = 8;
    localparam int unsigned NumClint    = 8;
    localparam int unsigned NumNdmChk   = 11;
    localparam int unsigned RtcPulses   = 5;
    localparam int unsigned RtcHalf     = 6;
    localparam int unsigned NumTxn      = NumRomRd + 2 * NumRomWr + SramWords + NumSramRnd +
                                          2 * NumArb + NumUnmapped + NumClint + NumNdmChk;
    // Up to four cycles per access plus rtc phases and both resets
    localparam int unsigned MaxCycles   = 4 * NumTxn + 2 * RtcPulses * RtcHalf +
                                          4 * ResetCycles + 50;

    logic              clk_i = 1'b0;
    logic              rst_n_i;
    logic              rtc_i;
    logic              ndmreset_i;
    logic              core_req_valid_i;
    logic              debug_req_valid_i;
    soc_pkg::bus_req_t core_req_i;
    soc_pkg::bus_req_t debug_req_i;
    logic              core_gnt_o;
    logic              debug_gnt_o;
    logic              core_rsp_valid_o;
    logic              debug_rsp_valid_o;
    soc_pkg::bus_rsp_t core_rsp_o;
    soc_pkg::bus_rsp_t debug_rsp_o;
    logic              timer_irq_o;
    logic              ipi_o;

    logic [31:0] rom_model [16];
    logic [31:0] sram_model [SramWords];
    logic [31:0] mtime_model;
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] data;
    integer      seed = 66012;
    int          errors = 0;
    int          checks = 0;
    int          cycle_cnt = 0;
    int          dbg_cyc;
    int          core_cyc;
    int          gcyc;
    int          idx;
    int          idx2;

    always #10 clk_i = ~clk_i;

    mini_soc #(
        .SramWords ( SramWords )
    ) i_mini_soc (
        .clk_i             ( clk_i             ),
        .rst_n_i           ( rst_n_i           ),
        .rtc_i             ( rtc_i             ),
        .ndmreset_i        ( ndmreset_i        ),
        .core_req_valid_i  ( core_req_valid_i  ),
        .core_req_i        ( core_req_i        ),
        .core_gnt_o        ( core_gnt_o        ),
        .core_rsp_valid_o  ( core_rsp_valid_o  ),
        .core_rsp_o        ( core_rsp_o        ),
        .debug_req_valid_i ( debug_req_valid_i ),
        .debug_req_i       ( debug_req_i       ),
        .debug_gnt_o       ( debug_gnt_o       ),
        .debug_rsp_valid_o ( debug_rsp_valid_o ),
        .debug_rsp_o       ( debug_rsp_o       ),
        .timer_irq_o       ( timer_irq_o       ),
        .ipi_o             ( ipi_o             )
    );

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MaxCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] wdata,
                                                input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old & ~mask) | (wdata & mask);
    endfunction

    // One bus access by one master, waits for the grant, checks the response
    task automatic transact(input string name, input logic dbg, input logic we,
                            input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, input logic [31:0] exp_rdata,
                            input logic exp_err, output int gnt_cycle);
        soc_pkg::bus_req_t req;
        soc_pkg::bus_rsp_t rsp;
        req.we    = we;
        req.addr  = addr;
        req.be    = be;
        req.wdata = wdata;
        @(posedge clk_i);
        if (dbg) begin
            debug_req_valid_i <= 1'b1;
            debug_req_i       <= req;
        end else begin
            core_req_valid_i <= 1'b1;
            core_req_i       <= req;
        end
        @(negedge clk_i);
        while (!(dbg ? debug_gnt_o : core_gnt_o)) begin
            @(negedge clk_i);
        end
        gnt_cycle = cycle_cnt;
        @(posedge clk_i);
        if (dbg) begin
            debug_req_valid_i <= 1'b0;
        end else begin
            core_req_valid_i <= 1'b0;
        end
        @(negedge clk_i);
        rsp = dbg ? debug_rsp_o : core_rsp_o;
        check({name, " rsp_valid"}, 1'b1, dbg ? debug_rsp_valid_o : core_rsp_valid_o);
        check({name, " other rsp_valid"}, 1'b0, dbg ? core_rsp_valid_o : debug_rsp_valid_o);
        check({name, " err"}, exp_err, rsp.err);
        if (!we || exp_err) begin
            check({name, " rdata"}, exp_rdata, rsp.rdata);
        end
    endtask

    task automatic rtc_pulses(input int count);
        repeat (count) begin
            @(posedge clk_i);
            rtc_i <= 1'b1;
            repeat (RtcHalf) @(posedge clk_i);
            rtc_i <= 1'b0;
            repeat (RtcHalf) @(posedge clk_i);
        end
    endtask

    initial begin
        $readmemh("hw/bootrom.hex", rom_model);
        rst_n_i           = 1'b0;
        rtc_i             = 1'b0;
        ndmreset_i        = 1'b0;
        core_req_valid_i  = 1'b0;
        debug_req_valid_i = 1'b0;
        core_req_i        = '0;
        debug_req_i       = '0;
        repeat (ResetCycles) @(posedge clk_i);
        rst_n_i <= 1'b1;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        check("idle grants", 2'b00, {core_gnt_o, debug_gnt_o});
        check("idle responses", 2'b00, {core_rsp_valid_o, debug_rsp_valid_o});
        check("idle interrupts", 2'b00, {timer_irq_o, ipi_o});

        // --------------------------------------------------
        // ROM, then SRAM fill and random traffic
        // --------------------------------------------------
        for (int i = 0; i < NumRomRd; i++) begin
            r = $random(seed);
            idx = r[3:0];
            transact("rom read", r[4], 1'b0, soc_pkg::RomBase + 4 * idx, 4'hf, '0,
                     rom_model[idx], 1'b0, gcyc);
        end
        for (int i = 0; i < NumRomWr; i++) begin
            r = $random(seed);
            data = $random(seed);
            idx = r[3:0];
            addr = soc_pkg::RomBase + 4 * idx;
            transact("rom write", r[4], 1'b1, addr, r[11:8], data, '0, 1'b1, gcyc);
            transact("rom reread", r[5], 1'b0, addr, 4'hf, '0, rom_model[idx], 1'b0, gcyc);
        end
        for (int i = 0; i < SramWords; i++) begin
            r = $random(seed);
            data = $random(seed);
            sram_model[i] = data;
            transact("sram fill", r[0], 1'b1, soc_pkg::DramBase + 4 * i, 4'hf, data, '0,
                     1'b0, gcyc);
        end
        for (int i = 0; i < NumSramRnd; i++) begin
            r = $random(seed);
            data = $random(seed);
            idx = r[15:8] % SramWords;
            addr = soc_pkg::DramBase + 4 * idx + r[17:16];
            if (r[1]) begin
                sram_model[idx] = merge_bytes(sram_model[idx], data, r[7:4]);
                transact("sram write", r[0], 1'b1, addr, r[7:4], data, '0, 1'b0, gcyc);
            end else begin
                transact("sram read", r[0], 1'b0, addr, 4'hf, '0, sram_model[idx], 1'b0, gcyc);
            end
        end

        // Both masters at once, debug must win
        for (int i = 0; i < NumArb; i++) begin
            r = $random(seed);
            idx = r[7:0] % SramWords;
            idx2 = r[15:8] % SramWords;
            fork
                transact("arb debug", 1'b1, 1'b0, soc_pkg::DramBase + 4 * idx, 4'hf, '0,
                         sram_model[idx], 1'b0, dbg_cyc);
                transact("arb core", 1'b0, 1'b0, soc_pkg::DramBase + 4 * idx2, 4'hf, '0,
                         sram_model[idx2], 1'b0, core_cyc);
            join
            check("arb debug first", 1'b1, dbg_cyc < core_cyc);
        end
        for (int i = 0; i < NumUnmapped; i++) begin
            r = $random(seed);
            data = $random(seed);
            case (r[1:0])
                2'd0:    addr = {20'h0, r[11:2], 2'b00};
                2'd1:    addr = soc_pkg::ClintBase + soc_pkg::ClintLength + {r[11:2], 2'b00};
                2'd2:    addr = soc_pkg::DramBase + 4 * SramWords + {r[11:2], 2'b00};
                default: addr = {2'b01, r[29:2], 2'b00};
            endcase
            transact("unmapped", r[2], r[3], addr, r[7:4], data, '0, 1'b1, gcyc);
        end

        // --------------------------------------------------
        // CLINT timer, compare and software interrupt
        // --------------------------------------------------
        rtc_pulses(RtcPulses);
        mtime_model = RtcPulses;
        addr = soc_pkg::ClintBase;
        transact("mtime", 1'b0, 1'b0, addr + soc_pkg::ClintMtimeOff, 4'hf, '0, mtime_model,
                 1'b0, gcyc);
        transact("mtimecmp low", 1'b1, 1'b1, addr + soc_pkg::ClintMtimecmpOff, 4'hf,
                 mtime_model - 1, '0, 1'b0, gcyc);
        repeat (2) @(negedge clk_i);
        check("timer irq set", 1'b1, timer_irq_o);
        transact("mtimecmp high", 1'b0, 1'b1, addr + soc_pkg::ClintMtimecmpOff, 4'hf,
                 mtime_model + 100, '0, 1'b0, gcyc);
        repeat (2) @(negedge clk_i);
        check("timer irq clear", 1'b0, timer_irq_o);
        transact("mtimecmp", 1'b1, 1'b0, addr + soc_pkg::ClintMtimecmpOff, 4'hf, '0,
                 mtime_model + 100, 1'b0, gcyc);
        transact("msip set", 1'b0, 1'b1, addr + soc_pkg::ClintMsipOff, 4'hf, 1, '0, 1'b0, gcyc);
        check("ipi set", 1'b1, ipi_o);
        transact("msip", 1'b1, 1'b0, addr + soc_pkg::ClintMsipOff, 4'hf, '0, 1, 1'b0, gcyc);
        transact("msip clear", 1'b0, 1'b1, addr + soc_pkg::ClintMsipOff, 4'hf, 0, '0, 1'b0, gcyc);
        check("ipi clear", 1'b0, ipi_o);
        transact("msip again", 1'b1, 1'b1, addr + soc_pkg::ClintMsipOff, 4'hf, 1, '0, 1'b0, gcyc);

        // --------------------------------------------------
        // ndmreset clears the CLINT, SRAM keeps its data
        // --------------------------------------------------
        @(posedge clk_i);
        ndmreset_i <= 1'b1;
        repeat (3) @(posedge clk_i);
        ndmreset_i <= 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        check("ipi after ndmreset", 1'b0, ipi_o);
        transact("ndm mtime", 1'b0, 1'b0, addr + soc_pkg::ClintMtimeOff, 4'hf, '0, 0, 1'b0, gcyc);
        transact("ndm msip", 1'b1, 1'b0, addr + soc_pkg::ClintMsipOff, 4'hf, '0, 0, 1'b0, gcyc);
        transact("ndm mtimecmp", 1'b0, 1'b0, addr + soc_pkg::ClintMtimecmpOff, 4'hf, '0,
                 32'hffff_ffff, 1'b0, gcyc);
        for (int i = 0; i < NumNdmChk - 3; i++) begin
            r = $random(seed);
            idx = r[15:8] % SramWords;
            transact("ndm sram", r[0], 1'b0, soc_pkg::DramBase + 4 * idx, 4'hf, '0,
                     sram_model[idx], 1'b0, gcyc);
        end

        repeat (2) @(posedge clk_i);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 i_mini_soc.i_mini_soc_assert.fail_cnt);
        if (errors == 0 && i_mini_soc.i_mini_soc_assert.fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== mini_soc.f ====
hw/soc_pkg.sv
hw/soc_rstgen.sv
hw/soc_arbiter.sv
hw/soc_decoder.sv
hw/soc_bootrom.sv
hw/soc_sram.sv
hw/soc_clint.sv
hw/mini_soc.sv
bench/mini_soc_assert.sv
bench/tb_mini_soc.sv

// ==== Bender.yml ====
package:
  name: mini_soc

sources:
  - hw/soc_pkg.sv
  - hw/soc_rstgen.sv
  - hw/soc_arbiter.sv
  - hw/soc_decoder.sv
  - hw/soc_bootrom.sv
  - hw/soc_sram.sv
  - hw/soc_clint.sv
  - hw/mini_soc.sv
  - target: test
    files:
      - bench/mini_soc_assert.sv
      - bench/tb_mini_soc.sv

// ==== hw/bootrom.hex ====
// Boot ROM image, one 32-bit word per line, word 0 first
f1402573
00000597
01858593
10500073
ffdff06f
80000337
00030067
00000013
12345678
9abcdef0
0badc0de
cafef00d
5a5aa5a5
0f0f1e1e
deadbeef
00c0ffee
